//--- ldpc_sched_ctrl.f
rtl/ldpc_sched_pkg.sv
rtl/ldpc_phase_pkg.sv
rtl/phase_timer.sv
rtl/decode_fsm.sv
rtl/ram_we_chain.sv
rtl/frame_overlap_ctrl.sv
rtl/ldpc_sched_ctrl.sv
verif/ldpc_sched_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ldpc_sched_ctrl_tb
FILELIST  ?= ldpc_sched_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/ldpc_sched_ctrl_tb.sv
`timescale 1ns/10ps

module ldpc_sched_ctrl_tb;

	localparam int Q        = 4;
	localparam int CNU_D    = 4;
	localparam int VNU_D    = 2;
	localparam int CN_ST    = 2;
	localparam int VN_ST    = 2;
	localparam bit INIT_IFE = 1'b1;  // non-default so that a disable reload shows
	localparam int N_ROWS   = 8;
	localparam int NONE     = -1;    // no pulse in this row
	localparam int RND      = -2;    // align cycle picked at random

	typedef struct packed {
		bit en;       // fsm_en_i for the whole row
		int term_at;  // cycle of the termination pulse
		int align_at; // cycle of the align pulse
		int len;      // row length in cycles
	} stim_row_t;

	logic read_clk = 1'b0;
	logic rstn, fsm_en_i, termination_i, inter_frame_align_i;
	ldpc_sched_pkg::dec_state_e    state;
	ldpc_sched_pkg::sched_strobe_t strobes;
	logic             v2c_load, c2v_load, dn_we, ife, dfs;
	logic [CN_ST-1:0] cn_we;
	logic [VN_ST-1:0] vn_we;

	stim_row_t   stim_tab [N_ROWS];
	int unsigned cycle_cnt   = 0;
	int unsigned cycle_limit = 1000;  // replaced once the table is loaded

	// reference model counting the cycles spent in each phase
	ldpc_sched_pkg::dec_state_e m_st;
	int                         m_cnt;
	logic [CN_ST-1:0]           m_cn;
	logic [VN_ST:0]             m_vn;   // top bit is the dn enable
	logic                       m_ife, m_dfs;

	ldpc_sched_ctrl #(
		.QUAN_SIZE (Q), .CNU_DEPTH (CNU_D), .VNU_DEPTH (VNU_D),
		.CN_STAGES (CN_ST), .VN_STAGES (VN_ST), .INIT_INTER_FRAME_EN (INIT_IFE)
	) UUT (
		.read_clk (read_clk), .rstn (rstn), .fsm_en_i (fsm_en_i),
		.termination_i (termination_i), .inter_frame_align_i (inter_frame_align_i),
		.state_o (state), .strobes_o (strobes), .v2c_load_o (v2c_load),
		.c2v_load_o (c2v_load), .cn_ram_we_o (cn_we), .vn_ram_we_o (vn_we),
		.dn_ram_we_o (dn_we), .inter_frame_en_o (ife), .de_frame_start_o (dfs)
	);

	always #2 read_clk = ~read_clk;  // 4 ns period

	always @(posedge read_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	//////////////////////////////////////////////////
	// reference rules
	function automatic int state_len(input ldpc_sched_pkg::dec_state_e st);
		case (st)
			ldpc_sched_pkg::LLR_FETCH, ldpc_sched_pkg::P2P_C, ldpc_sched_pkg::P2P_V:
				return Q;
			ldpc_sched_pkg::CNU_PIPE: return CNU_D + 1;
			ldpc_sched_pkg::VNU_PIPE: return VNU_D + 1;
			default: return 1;  // INIT_LOAD and the *_OUT states
		endcase
	endfunction

	function automatic ldpc_sched_pkg::sched_strobe_t exp_strobes(
		input ldpc_sched_pkg::dec_state_e st);
		ldpc_sched_pkg::sched_strobe_t s;
		s.llr_fetch  = st inside {ldpc_sched_pkg::INIT_LOAD, ldpc_sched_pkg::LLR_FETCH};
		s.v2c_src    = s.llr_fetch;
		s.v2c_msg_en = st inside {ldpc_sched_pkg::INIT_LOAD, ldpc_sched_pkg::LLR_FETCH,
			ldpc_sched_pkg::VNU_OUT, ldpc_sched_pkg::P2P_V};
		s.cnu_rd     = st inside {ldpc_sched_pkg::LLR_FETCH_OUT, ldpc_sched_pkg::CNU_PIPE,
			ldpc_sched_pkg::P2P_V_OUT};
		s.c2v_msg_en = st inside {ldpc_sched_pkg::CNU_OUT, ldpc_sched_pkg::P2P_C};
		s.vnu_rd     = st inside {ldpc_sched_pkg::P2P_C_OUT, ldpc_sched_pkg::VNU_PIPE};
		s.dnu_rd     = (st == ldpc_sched_pkg::P2P_V);
		return s;
	endfunction

	// one clock edge of the model with the inputs held over that edge
	task automatic model_step(input bit en, input bit term, input bit align);
		bit cn_set, vn_set, ife_set;
		cn_set  = (m_st == ldpc_sched_pkg::CNU_PIPE) && (m_cnt == 1);
		vn_set  = (m_st == ldpc_sched_pkg::VNU_PIPE) && (m_cnt == 1);
		ife_set = ((m_st == ldpc_sched_pkg::LLR_FETCH) && (m_cnt == Q-1)) ||
			((m_st == ldpc_sched_pkg::P2P_V) && (m_cnt == Q-1)) ||
			((m_st == ldpc_sched_pkg::VNU_PIPE) && (m_cnt == VNU_D-1));
		if (!en) begin
			m_cn = '0;
			m_vn = '0;
			m_ife = INIT_IFE;
		end else begin
			for (int i = CN_ST-1; i > 0; i--) m_cn[i] = m_cn[i-1];  // ripple before head
			for (int i = VN_ST; i > 0; i--) m_vn[i] = m_vn[i-1];
			if (cn_set) m_cn[0] = 1'b1;
			else if (m_st == ldpc_sched_pkg::P2P_V_OUT) m_cn[0] = 1'b0;
			if (vn_set) m_vn[0] = 1'b1;
			else if (m_st == ldpc_sched_pkg::P2P_C_OUT) m_vn[0] = 1'b0;
			if (ife_set) m_ife = 1'b1;
			else if (align) m_ife = 1'b0;
		end
		if (m_st == ldpc_sched_pkg::INIT_LOAD) m_dfs = 1'b1;
		else if (m_st == ldpc_sched_pkg::CNU_PIPE && term) m_dfs = 1'b0;
		if (!en || term) begin
			m_st  = ldpc_sched_pkg::INIT_LOAD;
			m_cnt = 0;
		end else if (m_cnt == state_len(m_st) - 1) begin
			m_st  = (m_st == ldpc_sched_pkg::P2P_V_OUT) ?
				ldpc_sched_pkg::CNU_PIPE : m_st.next();
			m_cnt = 0;
		end else begin
			m_cnt = m_cnt + 1;
		end
	endtask

	//////////////////////////////////////////////////
	// checks
	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0h, expected %0h",
				$time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_outputs();
		bit first;
		first = (m_cnt == 0);
		check_val("state_o", 32'(state), 32'(m_st));
		check_val("strobes_o", 32'(strobes), 32'(exp_strobes(m_st)));
		check_val("v2c_load_o", 32'(v2c_load),
			32'(first && (m_st == ldpc_sched_pkg::LLR_FETCH || m_st == ldpc_sched_pkg::P2P_V)));
		check_val("c2v_load_o", 32'(c2v_load),
			32'(first && m_st == ldpc_sched_pkg::P2P_C));
		check_val("cn_ram_we_o", 32'(cn_we), 32'(m_cn));
		check_val("vn_ram_we_o", 32'(vn_we), 32'(m_vn[VN_ST-1:0]));
		check_val("dn_ram_we_o", 32'(dn_we), 32'(m_vn[VN_ST]));
		check_val("inter_frame_en_o", 32'(ife), 32'(m_ife));
		check_val("de_frame_start_o", 32'(dfs), 32'(m_dfs));
	endtask

	task automatic load_table();
		stim_tab[0] = '{1'b0, NONE, NONE, 4};   // held in INIT_LOAD
		stim_tab[1] = '{1'b1, NONE, RND, 70};   // fetch plus three iterations
		stim_tab[2] = '{1'b1, 0, 2, 30};        // termination in CNU_PIPE then align in the fetch
		stim_tab[3] = '{1'b1, 3, 10, 20};       // termination in P2P_C leaves the chains up
		stim_tab[4] = '{1'b0, NONE, NONE, 5};   // disable empties the chains
		stim_tab[5] = '{1'b1, NONE, 12, 45};    // align in P2P_C ahead of the vnu mid point
		stim_tab[6] = '{1'b1, NONE, 16, 21};    // align on the first P2P_V cycle
		stim_tab[7] = '{1'b1, NONE, 12, 20};    // align on the vnu mid point where set wins
		cycle_limit = 20;
		for (int r = 0; r < N_ROWS; r++) cycle_limit += stim_tab[r].len;
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial begin
		int align_cyc;
		void'($urandom(35110));
		rstn = 1'b0;
		fsm_en_i = 1'b0;
		termination_i = 1'b0;
		inter_frame_align_i = 1'b0;
		m_st = ldpc_sched_pkg::INIT_LOAD;
		m_cnt = 0;
		m_cn = '0;
		m_vn = '0;
		m_ife = INIT_IFE;
		m_dfs = 1'b0;
		load_table();
		repeat (2) @(negedge read_clk);
		check_outputs();  // reset values
		rstn = 1'b1;
		model_step(fsm_en_i, termination_i, inter_frame_align_i);
		for (int r = 0; r < N_ROWS; r++) begin
			align_cyc = stim_tab[r].align_at;
			if (align_cyc == RND)
				align_cyc = int'($urandom % 32'(stim_tab[r].len));
			for (int k = 0; k < stim_tab[r].len; k++) begin
				@(negedge read_clk);
				check_outputs();
				fsm_en_i = stim_tab[r].en;
				termination_i = (k == stim_tab[r].term_at);
				inter_frame_align_i = (k == align_cyc);
				model_step(fsm_en_i, termination_i, inter_frame_align_i);
			end
		end
		@(negedge read_clk);
		check_outputs();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- rtl/ldpc_sched_ctrl.sv
`timescale 1ns/10ps

module ldpc_sched_ctrl #(
	parameter int QUAN_SIZE           = 4,     // message bit width
	parameter int CNU_DEPTH           = 4,     // check-node pipeline depth
	parameter int VNU_DEPTH           = 2,     // variable-node pipeline depth, 2 or more
	parameter int CN_STAGES           = 2,     // check-node decomposition stages
	parameter int VN_STAGES           = 2,     // variable-node decomposition stages
	parameter bit INIT_INTER_FRAME_EN = 1'b0
) (
	input  logic                          read_clk,
	input  logic                          rstn,
	input  logic                          fsm_en_i,
	input  logic                          termination_i,
	input  logic                          inter_frame_align_i,
	output ldpc_sched_pkg::dec_state_e    state_o,
	output ldpc_sched_pkg::sched_strobe_t strobes_o,
	output logic                          v2c_load_o,  // parallel-to-serial load, v2c
	output logic                          c2v_load_o,  // parallel-to-serial load, c2v
	output logic [CN_STAGES-1:0]          cn_ram_we_o,
	output logic [VN_STAGES-1:0]          vn_ram_we_o,
	output logic                          dn_ram_we_o,
	output logic                          inter_frame_en_o,
	output logic                          de_frame_start_o
);

	ldpc_phase_pkg::phase_flags_t flags;
	logic                         cn_we_clr;
	logic                         vn_we_clr;
	logic [VN_STAGES:0]           vn_we;  // vn stages plus the trailing dn bit

	//////////////////////////////////////////////////
	// schedule core
	phase_timer #(
		.QUAN_SIZE (QUAN_SIZE),
		.CNU_DEPTH (CNU_DEPTH),
		.VNU_DEPTH (VNU_DEPTH)
	) u_phase_timer (
		.read_clk (read_clk),
		.rstn     (rstn),
		.state_i  (state_o),
		.flags_o  (flags)
	);

	decode_fsm u_decode_fsm (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.fsm_en_i      (fsm_en_i),
		.termination_i (termination_i),
		.flags_i       (flags),
		.state_o       (state_o),
		.strobes_o     (strobes_o),
		.cn_we_clr_o   (cn_we_clr),
		.vn_we_clr_o   (vn_we_clr)
	);

	assign v2c_load_o = flags.v2c_load;
	assign c2v_load_o = flags.c2v_load;

	//////////////////////////////////////////////////
	// node ram write-enable chains
	ram_we_chain #(.LEN(CN_STAGES)) cn_chain (
		.read_clk (read_clk),
		.rstn     (rstn),
		.fsm_en_i (fsm_en_i),
		.set_i    (flags.cnu_second),
		.clr_i    (cn_we_clr),
		.we_o     (cn_ram_we_o)
	);

	// dn enable rides one stage behind the last vn stage
	ram_we_chain #(.LEN(VN_STAGES+1)) vn_chain (
		.read_clk (read_clk),
		.rstn     (rstn),
		.fsm_en_i (fsm_en_i),
		.set_i    (flags.vnu_second),
		.clr_i    (vn_we_clr),
		.we_o     (vn_we)
	);

	assign vn_ram_we_o = vn_we[VN_STAGES-1:0];
	assign dn_ram_we_o = vn_we[VN_STAGES];

	frame_overlap_ctrl #(
		.INIT_INTER_FRAME_EN (INIT_INTER_FRAME_EN)
	) u_frame_overlap_ctrl (
		.read_clk            (read_clk),
		.rstn                (rstn),
		.fsm_en_i            (fsm_en_i),
		.termination_i       (termination_i),
		.inter_frame_align_i (inter_frame_align_i),
		.state_i             (state_o),
		.flags_i             (flags),
		.inter_frame_en_o    (inter_frame_en_o),
		.de_frame_start_o    (de_frame_start_o)
	);

endmodule

//--- rtl/frame_overlap_ctrl.sv
`timescale 1ns/10ps

module frame_overlap_ctrl #(
	parameter bit INIT_INTER_FRAME_EN = 1'b0
) (
	input  logic                         read_clk,
	input  logic                         rstn,
	input  logic                         fsm_en_i,
	input  logic                         termination_i,
	input  logic                         inter_frame_align_i,  // other frame reached its sync point
	input  ldpc_sched_pkg::dec_state_e   state_i,
	input  ldpc_phase_pkg::phase_flags_t flags_i,
	output logic                         inter_frame_en_o,     // lets the second frame start
	output logic                         de_frame_start_o      // current frame has begun decoding
);

	logic ife_set;

	//////////////////////////////////////////////////
	// inter-frame enable
	// set at the tail of the llr fetch (first iteration), the tail of
	// P2P_V and one step before the vnu pipe tops out
	assign ife_set = (flags_i.v2c_last && (state_i == ldpc_sched_pkg::LLR_FETCH)) ||
		(flags_i.v2c_last && (state_i == ldpc_sched_pkg::P2P_V)) ||
		flags_i.vnu_mid;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			inter_frame_en_o <= INIT_INTER_FRAME_EN;
		else if (!fsm_en_i)
			inter_frame_en_o <= INIT_INTER_FRAME_EN;  // back to power-up value
		else if (ife_set)
			inter_frame_en_o <= 1'b1;  // set wins over align
		else if (inter_frame_align_i)
			inter_frame_en_o <= 1'b0;
	end

	// frame start flag, dropped once termination hits a check pass
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			de_frame_start_o <= 1'b0;
		else if (state_i == ldpc_sched_pkg::INIT_LOAD)
			de_frame_start_o <= 1'b1;
		else if (state_i == ldpc_sched_pkg::CNU_PIPE && termination_i)
			de_frame_start_o <= 1'b0;
	end

endmodule

//--- rtl/ram_we_chain.sv
`timescale 1ns/10ps

module ram_we_chain #(
	parameter int LEN = 2  // number of ripple stages
) (
	input  logic           read_clk,
	input  logic           rstn,
	input  logic           fsm_en_i,  // low empties the chain
	input  logic           set_i,     // raise the head flop
	input  logic           clr_i,     // drop the head flop
	output logic [LEN-1:0] we_o
);

	//////////////////////////////////////////////////
	// head flop plus ripple
	// stage k follows stage k-1 one cycle later, so the
	// decomposition stages of a node update in turn
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			we_o <= '0;
		end else if (!fsm_en_i) begin
			we_o <= '0;
		end else begin
			if (set_i)
				we_o[0] <= 1'b1;
			else if (clr_i)
				we_o[0] <= 1'b0;
			for (int k = 1; k < LEN; k++) begin
				we_o[k] <= we_o[k-1];  // ripple
			end
		end
	end

	// set comes from the pipe counter and clr from the fsm, the schedule keeps them apart
	a_set_clr_excl: assert property (@(posedge read_clk) disable iff (!rstn)
		!(set_i && clr_i))
		else $error("write-enable chain set and cleared in the same cycle");

endmodule

//--- rtl/decode_fsm.sv
`timescale 1ns/10ps

module decode_fsm (
	input  logic                         read_clk,
	input  logic                         rstn,
	input  logic                         fsm_en_i,       // low holds INIT_LOAD
	input  logic                         termination_i,  // current frame done
	input  ldpc_phase_pkg::phase_flags_t flags_i,
	output ldpc_sched_pkg::dec_state_e   state_o,
	output ldpc_sched_pkg::sched_strobe_t strobes_o,
	output logic                         cn_we_clr_o,    // drops the cn ram we chain
	output logic                         vn_we_clr_o     // drops the vn ram we chain
);

	ldpc_sched_pkg::dec_state_e state_q;
	ldpc_sched_pkg::dec_state_e state_d;

	//////////////////////////////////////////////////
	// next-state logic
	always_comb begin
		state_d = state_q;
		if (!fsm_en_i || termination_i) begin
			state_d = ldpc_sched_pkg::INIT_LOAD;  // disable or termination restarts the frame
		end else begin
			case (state_q)
				ldpc_sched_pkg::INIT_LOAD:
					state_d = ldpc_sched_pkg::LLR_FETCH;  // init load runs beside the fetch
				ldpc_sched_pkg::LLR_FETCH: begin
					if (flags_i.v2c_last)
						state_d = ldpc_sched_pkg::LLR_FETCH_OUT;
				end
				ldpc_sched_pkg::LLR_FETCH_OUT:
					state_d = ldpc_sched_pkg::CNU_PIPE;
				ldpc_sched_pkg::CNU_PIPE: begin
					if (flags_i.cnu_last)
						state_d = ldpc_sched_pkg::CNU_OUT;
				end
				ldpc_sched_pkg::CNU_OUT:
					state_d = ldpc_sched_pkg::P2P_C;
				ldpc_sched_pkg::P2P_C: begin
					if (flags_i.c2v_last)
						state_d = ldpc_sched_pkg::P2P_C_OUT;
				end
				ldpc_sched_pkg::P2P_C_OUT:
					state_d = ldpc_sched_pkg::VNU_PIPE;
				ldpc_sched_pkg::VNU_PIPE: begin
					if (flags_i.vnu_last)
						state_d = ldpc_sched_pkg::VNU_OUT;
				end
				ldpc_sched_pkg::VNU_OUT:
					state_d = ldpc_sched_pkg::P2P_V;
				ldpc_sched_pkg::P2P_V: begin
					if (flags_i.v2c_last)
						state_d = ldpc_sched_pkg::P2P_V_OUT;
				end
				ldpc_sched_pkg::P2P_V_OUT:
					state_d = ldpc_sched_pkg::CNU_PIPE;  // next iteration
				default:
					state_d = ldpc_sched_pkg::INIT_LOAD;
			endcase
		end
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			state_q <= ldpc_sched_pkg::INIT_LOAD;
		else
			state_q <= state_d;
	end

	assign state_o = state_q;

	//////////////////////////////////////////////////
	// strobe and clear decode, purely from the state
	always_comb begin
		strobes_o.llr_fetch  = (state_q == ldpc_sched_pkg::INIT_LOAD) ||
			(state_q == ldpc_sched_pkg::LLR_FETCH);
		strobes_o.v2c_src    = strobes_o.llr_fetch;  // channel llr feeds v2c while fetching
		strobes_o.v2c_msg_en = strobes_o.llr_fetch ||
			(state_q == ldpc_sched_pkg::VNU_OUT) || (state_q == ldpc_sched_pkg::P2P_V);
		strobes_o.cnu_rd     = (state_q == ldpc_sched_pkg::LLR_FETCH_OUT) ||
			(state_q == ldpc_sched_pkg::CNU_PIPE) || (state_q == ldpc_sched_pkg::P2P_V_OUT);
		strobes_o.c2v_msg_en = (state_q == ldpc_sched_pkg::CNU_OUT) ||
			(state_q == ldpc_sched_pkg::P2P_C);
		strobes_o.vnu_rd     = (state_q == ldpc_sched_pkg::P2P_C_OUT) ||
			(state_q == ldpc_sched_pkg::VNU_PIPE);
		strobes_o.dnu_rd     = (state_q == ldpc_sched_pkg::P2P_V);
	end

	assign cn_we_clr_o = (state_q == ldpc_sched_pkg::P2P_V_OUT);  // cn ram done for this pass
	assign vn_we_clr_o = (state_q == ldpc_sched_pkg::P2P_C_OUT);

	// state register only ever holds one of the eleven phases
	a_state_legal: assert property (@(posedge read_clk) disable iff (!rstn)
		!$isunknown(state_q) && (state_q <= ldpc_sched_pkg::P2P_V_OUT))
		else $error("decoder state left the legal range");

endmodule

//--- rtl/phase_timer.sv
`timescale 1ns/10ps

module phase_timer #(
	parameter int QUAN_SIZE = 4,  // message bit width
	parameter int CNU_DEPTH = 4,  // check-node pipeline depth
	parameter int VNU_DEPTH = 2   // variable-node pipeline depth, 2 or more
) (
	input  logic                         read_clk,
	input  logic                         rstn,
	input  ldpc_sched_pkg::dec_state_e   state_i,
	output ldpc_phase_pkg::phase_flags_t flags_o
);

	logic [QUAN_SIZE:0]   v2c_sr;   // one-hot bit position of the v2c transfer
	logic [QUAN_SIZE:0]   c2v_sr;   // one-hot bit position of the c2v transfer
	logic [CNU_DEPTH-1:0] cnu_lvl;  // one-hot check-node pipe level
	logic [VNU_DEPTH-1:0] vnu_lvl;  // one-hot variable-node pipe level
	logic                 in_cnu_pipe;
	logic                 in_vnu_pipe;

	assign in_cnu_pipe = (state_i == ldpc_sched_pkg::CNU_PIPE);
	assign in_vnu_pipe = (state_i == ldpc_sched_pkg::VNU_PIPE);

	//////////////////////////////////////////////////
	// bit-serial message counters

	// v2c: armed in INIT_LOAD / VNU_OUT, walks one bit per cycle
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			v2c_sr <= '0;
		else if (state_i == ldpc_sched_pkg::INIT_LOAD || state_i == ldpc_sched_pkg::VNU_OUT)
			v2c_sr <= (QUAN_SIZE+1)'(1);
		else if (state_i == ldpc_sched_pkg::LLR_FETCH || state_i == ldpc_sched_pkg::P2P_V)
			v2c_sr <= v2c_sr << 1;
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			c2v_sr <= '0;
		else if (state_i == ldpc_sched_pkg::CNU_OUT)
			c2v_sr <= (QUAN_SIZE+1)'(1);  // armed one cycle ahead of P2P_C
		else if (state_i == ldpc_sched_pkg::P2P_C)
			c2v_sr <= c2v_sr << 1;
	end

	//////////////////////////////////////////////////
	// node pipeline depth counters
	// zero on the first pipe cycle, bit 0 on the second, ...
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			cnu_lvl <= '0;
		else if (!in_cnu_pipe)
			cnu_lvl <= '0;
		else if (cnu_lvl == '0)
			cnu_lvl <= CNU_DEPTH'(1);
		else
			cnu_lvl <= cnu_lvl << 1;  // top bit drops out as the fsm leaves
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn)
			vnu_lvl <= '0;
		else if (!in_vnu_pipe)
			vnu_lvl <= '0;
		else if (vnu_lvl == '0)
			vnu_lvl <= VNU_DEPTH'(1);
		else
			vnu_lvl <= vnu_lvl << 1;
	end

	// flag decode
	always_comb begin
		flags_o.v2c_last   = v2c_sr[QUAN_SIZE-1];  // last of Q transfer cycles
		flags_o.c2v_last   = c2v_sr[QUAN_SIZE-1];
		flags_o.cnu_last   = cnu_lvl[CNU_DEPTH-1];
		flags_o.vnu_last   = vnu_lvl[VNU_DEPTH-1];
		flags_o.cnu_second = in_cnu_pipe && cnu_lvl[0];  // gated, a stale level can outlive the pipe
		flags_o.vnu_second = in_vnu_pipe && vnu_lvl[0];
		flags_o.vnu_mid    = in_vnu_pipe && vnu_lvl[VNU_DEPTH-2];
		flags_o.v2c_load   = v2c_sr[0] &&
			(state_i == ldpc_sched_pkg::LLR_FETCH || state_i == ldpc_sched_pkg::P2P_V);
		flags_o.c2v_load   = c2v_sr[0] && (state_i == ldpc_sched_pkg::P2P_C);
	end

	// message and depth counters never hold more than one token
	a_onehot_counters: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot0(v2c_sr) && $onehot0(c2v_sr) && $onehot0(cnu_lvl) && $onehot0(vnu_lvl))
		else $error("phase counter lost its one-hot token");

endmodule

//--- rtl/ldpc_phase_pkg.sv
package ldpc_phase_pkg;

	//////////////////////////////////////////////////
	// decoded flags of the phase counters
	// the *_last bits steer the fsm, the rest feed the
	// write-enable chains, the overlap logic and the
	// parallel-to-serial converters
	typedef struct packed {
		logic v2c_last;    // v2c shift at its top bit
		logic c2v_last;    // c2v shift at its top bit
		logic cnu_last;    // check-node depth at its top
		logic vnu_last;    // variable-node depth at its top
		logic cnu_second;  // second CNU_PIPE cycle
		logic vnu_second;  // second VNU_PIPE cycle
		logic vnu_mid;     // vnu depth one below its top
		logic v2c_load;    // load a new v2c word
		logic c2v_load;    // load a new c2v word
	} phase_flags_t;

endpackage

//--- rtl/ldpc_sched_pkg.sv
package ldpc_sched_pkg;

	//////////////////////////////////////////////////
	// decoder phase states
	typedef enum logic [3:0] {
		INIT_LOAD     = 4'd0,  // first cycle of a new frame
		LLR_FETCH     = 4'd1,  // channel llr fetched bit-serially
		LLR_FETCH_OUT = 4'd2,
		CNU_PIPE      = 4'd3,  // check-node pipeline filling
		CNU_OUT       = 4'd4,
		P2P_C         = 4'd5,  // c2v message shifted out bit by bit
		P2P_C_OUT     = 4'd6,
		VNU_PIPE      = 4'd7,  // variable-node pipeline filling
		VNU_OUT       = 4'd8,
		P2P_V         = 4'd9,  // v2c message shifted out bit by bit
		P2P_V_OUT     = 4'd10  // loops back to CNU_PIPE
	} dec_state_e;

	//////////////////////////////////////////////////
	// read and message strobes decoded from the state
	typedef struct packed {
		logic llr_fetch;   // channel llr read
		logic v2c_src;     // v2c source is channel llr
		logic v2c_msg_en;  // v2c serial path active
		logic cnu_rd;      // check-node ib-ram read
		logic c2v_msg_en;  // c2v serial path active
		logic vnu_rd;      // variable-node ib-ram read
		logic dnu_rd;      // decision-node ib-ram read
	} sched_strobe_t;

endpackage
